//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP      ?= clkDataOutputTb
FILELIST ?= build.f
LOG      ?= sim.log
OBJ_DIR  ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP), fails if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/clkDataTbUtil.svh
`ifndef CLKDATA_TB_UTIL_SVH
`define CLKDATA_TB_UTIL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsrStep(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
endfunction

// Symbol clock after the divider has run for the given number of cycles
function automatic logic expectedClk(input clkPhase_t phase, input int unsigned cycles);
    logic [1:0] state;
    case (cycles % 4)
        0:       state = 2'b00;
        1:       state = 2'b01;
        2:       state = 2'b11;
        default: state = 2'b10;
    endcase
    case (phase)
        phase0:   return state[0];
        phase90:  return state[1];
        phase180: return !state[0];
        default:  return !state[1];
    endcase
endfunction

function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                           input logic [3:0] byteEn);
    logic [31:0] merged;
    merged = old;
    for (int lane = 0; lane < 4; lane++) begin
        if (byteEn[lane]) merged[8*lane +: 8] = data[8*lane +: 8];
    end
    return merged;
endfunction

function automatic logic [31:0] makeCtrl(input logic run, input clkPhase_t phase,
                                         input outSelect_t sel, input int start);
    logic [31:0] word;
    word = '0;
    word[`CD_CTRL_RUN_BIT] = run;
    word[`CD_CTRL_PHASE_MSB:`CD_CTRL_PHASE_LSB] = phase;
    word[`CD_CTRL_OUTSEL_MSB:`CD_CTRL_OUTSEL_LSB] = sel;
    word[`CD_CTRL_START_MSB:`CD_CTRL_START_LSB] = fifoLevel_t'(start);
    return word;
endfunction

function automatic logic [31:0] statusExpected(input int level, input logic underflow);
    logic [31:0] word;
    word = '0;
    word[`CD_STAT_LEVEL_MSB:`CD_STAT_LEVEL_LSB] = fifoLevel_t'(level);
    word[`CD_STAT_UNDERFLOW_BIT] = underflow;
    return word;
endfunction

task automatic compareSymbol(input string what, input symbol_t exp, input symbol_t act);
    if (exp !== act) begin
        stopWithFailure($sformatf("Mismatch %s %s: expected %0h actual %0h",
                                  testName, what, exp, act));
    end
endtask

task automatic compareBit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
        stopWithFailure($sformatf("Mismatch %s %s: expected %0b actual %0b",
                                  testName, what, exp, act));
    end
endtask

task automatic compareWord(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
        stopWithFailure($sformatf("Mismatch %s %s: expected %08h actual %08h",
                                  testName, what, exp, act));
    end
endtask

`endif

//--- bench/clkDataOutputTb.sv
`timescale 1ns/1ps

`include "clkData_cfg.svh"

module clkDataOutputTb
    import clkDataPkg::*;
();
    // Nominal cycle budgets of the tests
    localparam int testCycles = 10 + 40 + 200 + 500 + 80 + 40 + 300;
    localparam int depth = `CD_FIFO_DEPTH;
    // Longest drain of a full FIFO, one pop per four cycles
    localparam int drainLimit = depth * 4 + 16;

    logic        dllOutputClk = 1'b0;
    logic        rst = 1'b1;
    logic        cs = 1'b0;
    logic        wr = 1'b0;
    logic [3:0]  byteEn = '0;
    logic [12:0] addr = '0;
    logic [31:0] din = '0;
    logic [31:0] dout;
    logic        symbolValid = 1'b0;
    symbol_t     symbol = '0;
    logic        creditReturn;
    logic        outputClk;
    symbol_t     outputData;

    string       testName = "reset";
    logic [15:0] lfsr = 16'd30513;
    int          credits = depth;
    int          sendRemaining = 0;
    logic        randomGaps = 1'b0;
    symbol_t     sentQueue[$];
    symbol_t     lastSent = '0;
    logic        goBit;
    logic [2:0]  drawn;

    // Reference model state
    logic [31:0] modelCtrl;
    int unsigned divCycles;
    int          fifoCount;
    logic        modelPrimed;
    logic        modelUnderflow;
    logic        expCredit;
    logic        phasedClk;
    symbol_t     phasedData;
    logic        bypClk;
    symbol_t     bypData;
    logic        expOutClk;
    symbol_t     expOutData;
    logic        strobe;

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    `include "clkDataTbUtil.svh"

    clkDataOutput clkDataOutput_i (
        .dllOutputClk (dllOutputClk),
        .rst          (rst),
        .cs           (cs),
        .wr           (wr),
        .byteEn       (byteEn),
        .addr         (addr),
        .din          (din),
        .dout         (dout),
        .symbolValid  (symbolValid),
        .symbol       (symbol),
        .creditReturn (creditReturn),
        .outputClk    (outputClk),
        .outputData   (outputData)
    );

    always #5 dllOutputClk = !dllOutputClk;

    initial begin
        #((testCycles * 4 + 200) * 10);
        stopWithFailure("Watchdog timeout, the run did not finish in time");
    end

    task automatic drawBits(input int count, output logic [2:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsrStep(lfsr);
            value = {value[1:0], lfsr[0]};
        end
    endtask

    // Sender spends one credit per presented symbol
    always @(posedge dllOutputClk) begin
        #1;
        symbolValid = 1'b0;
        if (!rst && sendRemaining > 0 && credits > 0) begin
            goBit = 1'b1;
            if (randomGaps) begin
                drawBits(1, drawn);
                goBit = drawn[0];
            end
            if (goBit) begin
                drawBits(3, drawn);
                symbol = drawn;
                symbolValid = 1'b1;
                credits--;
                sendRemaining--;
                lastSent = drawn;
                sentQueue.push_back(drawn);
            end
        end
    end

    always @(negedge dllOutputClk) begin
        if (rst) begin
            credits = depth;
        end else if (creditReturn) begin
            credits++;
            if (credits > depth) stopWithFailure("More credits returned than symbols sent");
        end
    end

    // Model steps on the edge, outputs compared mid cycle
    always @(posedge dllOutputClk) begin
        if (rst) begin
            modelCtrl = makeCtrl(1'b0, phase0, selPhased, `CD_START_LEVEL_RESET);
            divCycles = 0;
            fifoCount = 0;
            modelPrimed = 1'b0;
            modelUnderflow = 1'b0;
            expCredit = 1'b0;
            phasedClk = 1'b0;
            phasedData = '0;
            bypClk = 1'b0;
            bypData = '0;
        end else begin
            strobe = modelCtrl[`CD_CTRL_RUN_BIT] && (divCycles % 4 == 0);
            phasedClk = expectedClk(
                clkPhase_t'(modelCtrl[`CD_CTRL_PHASE_MSB:`CD_CTRL_PHASE_LSB]), divCycles);
            expCredit = 1'b0;
            if (strobe && (modelPrimed ||
                    fifoCount >= int'(modelCtrl[`CD_CTRL_START_MSB:`CD_CTRL_START_LSB]))) begin
                modelPrimed = 1'b1;
                if (fifoCount > 0) begin
                    phasedData = sentQueue.pop_front();
                    fifoCount--;
                    expCredit = 1'b1;
                end else begin
                    modelUnderflow = 1'b1;
                end
            end
            if (symbolValid) fifoCount++;
            if (modelCtrl[`CD_CTRL_RUN_BIT]) divCycles++;
            bypClk = symbolValid;
            bypData = symbol;
            if (cs && wr && addr == `CD_ADDR_CTRL) modelCtrl = mergeBytes(modelCtrl, din, byteEn);
        end
        if (modelCtrl[`CD_CTRL_OUTSEL_MSB:`CD_CTRL_OUTSEL_LSB] == selBypass) begin
            expOutClk = bypClk;
            expOutData = bypData;
        end else begin
            expOutClk = phasedClk;
            expOutData = phasedData;
        end
    end

    always @(negedge dllOutputClk) begin
        if (!rst) begin
            compareBit("creditReturn", expCredit, creditReturn);
            compareBit("outputClk", expOutClk, outputClk);
            compareSymbol("outputData", expOutData, outputData);
        end
    end

    task automatic busWrite(input logic [12:0] a, input logic [31:0] data, input logic [3:0] be);
        @(posedge dllOutputClk);
        #1;
        cs = 1'b1;
        wr = 1'b1;
        addr = a;
        din = data;
        byteEn = be;
        @(posedge dllOutputClk);
        #1;
        cs = 1'b0;
        wr = 1'b0;
    endtask

    task automatic busRead(input logic [12:0] a, output logic [31:0] data);
        @(posedge dllOutputClk);
        #1;
        cs = 1'b1;
        addr = a;
        @(negedge dllOutputClk);
        data = dout;
        @(posedge dllOutputClk);
        #1;
        cs = 1'b0;
    endtask

    task automatic checkStatus();
        logic [31:0] word;
        busRead(`CD_ADDR_STATUS, word);
        compareWord("status", statusExpected(fifoCount, modelUnderflow), word);
    endtask

    task automatic sendAndWait(input int count, input logic gaps);
        randomGaps = gaps;
        sendRemaining = count;
        wait (sendRemaining == 0);
    endtask

    // Every credit must come back within one full drain
    task automatic waitDrain();
        int waited;
        waited = 0;
        while (sendRemaining != 0 || credits != depth) begin
            if (waited == drainLimit) begin
                stopWithFailure("Credits did not return to the FIFO depth after the drain");
            end
            @(posedge dllOutputClk);
            waited++;
        end
        repeat (8) @(posedge dllOutputClk);
    endtask

    initial begin
        logic [31:0] word;
        logic [31:0] resetCtrl;
        resetCtrl = makeCtrl(1'b0, phase0, selPhased, `CD_START_LEVEL_RESET);
        repeat (10) @(posedge dllOutputClk);
        #1;
        rst = 1'b0;

        testName = "registers";
        busRead(`CD_ADDR_CTRL, word);
        compareWord("ctrl reset", resetCtrl, word);
        busWrite(`CD_ADDR_CTRL, 32'hA5C3_0E70, 4'b0110);
        busRead(`CD_ADDR_CTRL, word);
        compareWord("ctrl merge", mergeBytes(resetCtrl, 32'hA5C3_0E70, 4'b0110), word);
        busWrite(`CD_ADDR_CTRL, resetCtrl, 4'b1111);
        checkStatus();

        testName = "priming";
        busWrite(`CD_ADDR_CTRL, makeCtrl(1'b1, phase0, selPhased, 8), 4'b1111);
        sendAndWait(5, 1'b0);
        repeat (40) @(posedge dllOutputClk);
        checkStatus();
        busRead(`CD_ADDR_STATUS, word);
        compareWord("level below start", statusExpected(5, 1'b0), word);
        sendAndWait(10, 1'b0);
        waitDrain();

        testName = "credits";
        sendAndWait(80, 1'b1);
        waitDrain();

        testName = "underflow";
        repeat (8) @(posedge dllOutputClk);
        busRead(`CD_ADDR_STATUS, word);
        compareBit("underflow bit", 1'b1, word[`CD_STAT_UNDERFLOW_BIT]);
        compareSymbol("held outputData", lastSent, outputData);

        testName = "phase";
        for (int p = 0; p < 4; p++) begin
            busWrite(`CD_ADDR_CTRL, makeCtrl(1'b1, clkPhase_t'(p), selPhased, 8), 4'b1111);
            repeat (16) @(posedge dllOutputClk);
        end

        testName = "bypass";
        busWrite(`CD_ADDR_CTRL, makeCtrl(1'b1, phase90, selBypass, 8), 4'b1111);
        sendAndWait(12, 1'b1);
        repeat (4) @(posedge dllOutputClk);
        busWrite(`CD_ADDR_CTRL, makeCtrl(1'b1, phase90, selPhased, 8), 4'b1111);
        waitDrain();
        checkStatus();

        $display("Test OK");
        $finish;
    end

endmodule

//--- build.f
+incdir+design
+incdir+bench
design/clkDataPkg.sv
design/clkDataIfs.sv
design/clkDataRegs.sv
design/jitterFifo.sv
design/phaseClockGen.sv
design/clkDataOutput.sv
bench/clkDataOutputTb.sv

//--- design/clkDataIfs.sv
`timescale 1ns/1ps

// Control fields out of the register block, FIFO status back into it
interface clkCfgIf
    import clkDataPkg::*;
();
    logic       run;
    clkPhase_t  phase;
    outSelect_t outSelect;
    fifoLevel_t startLevel;
    fifoLevel_t level;
    logic       underflow;

    modport regs (
        output run,
        output phase,
        output outSelect,
        output startLevel,
        input  level,
        input  underflow
    );

    modport fifo (
        input  run,
        input  startLevel,
        output level,
        output underflow
    );

    modport clkGen (
        input  run,
        input  phase,
        input  outSelect
    );
endinterface

// Read side of the jitter FIFO, all fields valid in the strobe cycle
interface symbolReadIf
    import clkDataPkg::*;
();
    logic    readStrobe;
    symbol_t symbol;
    logic    valid;
    logic    underflowHit;

    modport fifo (
        input  readStrobe,
        output symbol,
        output valid,
        output underflowHit
    );

    modport clkGen (
        output readStrobe,
        input  symbol,
        input  valid,
        input  underflowHit
    );
endinterface

//--- design/clkDataOutput.sv
`timescale 1ns/1ps

`include "clkData_cfg.svh"

module clkDataOutput
    import clkDataPkg::*;
(
    input  logic        dllOutputClk,
    input  logic        rst,
    input  logic        cs,
    input  logic        wr,
    input  logic [3:0]  byteEn,
    input  logic [12:0] addr,
    input  logic [31:0] din,
    output logic [31:0] dout,
    input  logic        symbolValid,
    input  symbol_t     symbol,
    output logic        creditReturn,
    output logic        outputClk,
    output symbol_t     outputData
);

    clkCfgIf     cfgBus ();
    symbolReadIf readBus ();

    logic    phasedClk;
    symbol_t phasedData;
    logic    bypassClk;
    symbol_t bypassData;

    clkDataRegs regs_i (
        .dllOutputClk (dllOutputClk),
        .rst          (rst),
        .cs           (cs),
        .wr           (wr),
        .byteEn       (byteEn),
        .addr         (addr),
        .din          (din),
        .dout         (dout),
        .cfg          (cfgBus)
    );

    jitterFifo #(
        .payload_t (symbol_t),
        .depth     (`CD_FIFO_DEPTH)
    ) fifo_i (
        .dllOutputClk (dllOutputClk),
        .rst          (rst),
        .wrEn         (symbolValid),
        .wrData       (symbol),
        .rd           (readBus),
        .cfg          (cfgBus),
        .creditReturn (creditReturn)
    );

    phaseClockGen clkGen_i (
        .dllOutputClk (dllOutputClk),
        .rst          (rst),
        .cfg          (cfgBus),
        .rd           (readBus),
        .symbolClk    (phasedClk),
        .symbolData   (phasedData)
    );

    // Input strobe and symbol straight through, one edge late
    always_ff @(posedge dllOutputClk) begin
        if (rst) begin
            bypassClk  <= 1'b0;
            bypassData <= '0;
        end else begin
            bypassClk  <= symbolValid;
            bypassData <= symbol;
        end
    end

    always_comb begin
        case (cfgBus.outSelect)
            selBypass: begin
                outputClk  = bypassClk;
                outputData = bypassData;
            end
            default: begin
                outputClk  = phasedClk;
                outputData = phasedData;
            end
        endcase
    end

endmodule

//--- design/clkDataPkg.sv
package clkDataPkg;

    `include "clkData_cfg.svh"

    typedef logic [2:0] symbol_t;

    typedef enum logic [1:0] {phase0 = 2'b00, phase90 = 2'b01, phase180 = 2'b10, phase270 = 2'b11} clkPhase_t;

    // Codes 2 and 3 behave as selPhased
    typedef enum logic [1:0] {selPhased = 2'b00, selBypass = 2'b01} outSelect_t;

    typedef logic [`CD_LEVEL_WIDTH-1:0] fifoLevel_t;

    // Gray sequence 00 -> 01 -> 11 -> 10
    function automatic logic [1:0] grayNext(input logic [1:0] state);
        logic [1:0] next;
        case (state)
            2'b00:   next = 2'b01;
            2'b01:   next = 2'b11;
            2'b11:   next = 2'b10;
            default: next = 2'b00;
        endcase
        return next;
    endfunction

    // Pick one of the four quadrature taps of the divider
    function automatic logic phaseTap(input clkPhase_t phase, input logic [1:0] divider);
        logic tap;
        case (phase)
            phase0:   tap = divider[0];
            phase90:  tap = divider[1];
            phase180: tap = ~divider[0];
            default:  tap = ~divider[1];
        endcase
        return tap;
    endfunction

endpackage

//--- design/clkDataRegs.sv
`timescale 1ns/1ps

`include "clkData_cfg.svh"

module clkDataRegs
    import clkDataPkg::*;
(
    input  logic        dllOutputClk,
    input  logic        rst,
    input  logic        cs,
    input  logic        wr,
    input  logic [3:0]  byteEn,
    input  logic [12:0] addr,
    input  logic [31:0] din,
    output logic [31:0] dout,
    clkCfgIf.regs       cfg
);

    localparam logic [31:0] ctrlResetValue =
        32'(`CD_START_LEVEL_RESET) << `CD_CTRL_START_LSB;

    logic [31:0] ctrlWord;
    logic [31:0] statusWord;
    logic        ctrlWrite;

    assign ctrlWrite = cs && wr && (addr == `CD_ADDR_CTRL);

    // Byte lanes update independently
    always_ff @(posedge dllOutputClk) begin
        if (rst) begin
            ctrlWord <= ctrlResetValue;
        end else if (ctrlWrite) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteEn[lane]) begin
                    ctrlWord[8*lane +: 8] <= din[8*lane +: 8];
                end
            end
        end
    end

    assign cfg.run        = ctrlWord[`CD_CTRL_RUN_BIT];
    assign cfg.phase      = clkPhase_t'(ctrlWord[`CD_CTRL_PHASE_MSB:`CD_CTRL_PHASE_LSB]);
    assign cfg.outSelect  = outSelect_t'(ctrlWord[`CD_CTRL_OUTSEL_MSB:`CD_CTRL_OUTSEL_LSB]);
    assign cfg.startLevel = ctrlWord[`CD_CTRL_START_MSB:`CD_CTRL_START_LSB];

    // Live view of the FIFO
    always_comb begin
        statusWord = '0;
        statusWord[`CD_STAT_LEVEL_MSB:`CD_STAT_LEVEL_LSB] = cfg.level;
        statusWord[`CD_STAT_UNDERFLOW_BIT] = cfg.underflow;
    end

    always_comb begin
        dout = '0;
        if (cs) begin
            case (addr)
                `CD_ADDR_CTRL:   dout = ctrlWord;
                `CD_ADDR_STATUS: dout = statusWord;
                default:         dout = '0;
            endcase
        end
    end

endmodule

//--- design/clkData_cfg.svh
`ifndef CLKDATA_CFG_SVH
`define CLKDATA_CFG_SVH

// FIFO sizing
`define CD_FIFO_DEPTH           16
// Level field must hold the full depth
`define CD_LEVEL_WIDTH          5
// Start reading at half full
`define CD_START_LEVEL_RESET    8

// Register map
`define CD_ADDR_CTRL            13'h000
`define CD_ADDR_STATUS          13'h004

// Control word fields
`define CD_CTRL_RUN_BIT         0
`define CD_CTRL_PHASE_LSB       4
`define CD_CTRL_PHASE_MSB       5
`define CD_CTRL_OUTSEL_LSB      8
`define CD_CTRL_OUTSEL_MSB      9
`define CD_CTRL_START_LSB       16
`define CD_CTRL_START_MSB       (`CD_CTRL_START_LSB + `CD_LEVEL_WIDTH - 1)

// Status word fields
`define CD_STAT_LEVEL_LSB       0
`define CD_STAT_LEVEL_MSB       (`CD_STAT_LEVEL_LSB + `CD_LEVEL_WIDTH - 1)
`define CD_STAT_UNDERFLOW_BIT   8

`endif

//--- design/jitterFifo.sv
`timescale 1ns/1ps

`include "clkData_cfg.svh"

module jitterFifo
    import clkDataPkg::*;
#(
    parameter type payload_t = logic,
    parameter int  depth     = `CD_FIFO_DEPTH
) (
    input  logic     dllOutputClk,
    input  logic     rst,
    input  logic     wrEn,
    input  payload_t wrData,
    symbolReadIf.fifo rd,
    clkCfgIf.fifo     cfg,
    output logic     creditReturn
);

    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;

    payload_t            mem [depth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    fifoLevel_t          count;
    logic                primed;
    logic                underflowSticky;
    logic                empty;
    logic                full;
    logic                startReached;
    logic                primedNow;
    logic                strobe;
    logic                push;
    logic                pop;

    function automatic logic [ptrWidth-1:0] bump(input logic [ptrWidth-1:0] ptr);
        return (ptr == ptrWidth'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty        = (count == '0);
    assign full         = (count == fifoLevel_t'(depth));
    assign startReached = (count >= cfg.startLevel);
    assign strobe       = cfg.run && rd.readStrobe;

    // The strobe that first sees the start level already reads
    assign primedNow = primed || startReached;

    // Credits keep the sender from ever reaching full
    assign push = wrEn && !full;
    assign pop  = strobe && primedNow && !empty;

    assign rd.symbol       = mem[rdPtr];
    assign rd.valid        = pop;
    assign rd.underflowHit = strobe && primedNow && empty;

    assign cfg.level     = count;
    assign cfg.underflow = underflowSticky;

    always_ff @(posedge dllOutputClk) begin
        if (push) begin
            mem[wrPtr] <= wrData;
        end
    end

    always_ff @(posedge dllOutputClk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= bump(wrPtr);
            end
            if (pop) begin
                rdPtr <= bump(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Primed and underflow only clear on reset
    always_ff @(posedge dllOutputClk) begin
        if (rst) begin
            primed          <= 1'b0;
            underflowSticky <= 1'b0;
            creditReturn    <= 1'b0;
        end else begin
            if (strobe && startReached) begin
                primed <= 1'b1;
            end
            if (rd.underflowHit) begin
                underflowSticky <= 1'b1;
            end
            creditReturn <= pop;
        end
    end

endmodule

//--- design/phaseClockGen.sv
`timescale 1ns/1ps

module phaseClockGen
    import clkDataPkg::*;
(
    input  logic        dllOutputClk,
    input  logic        rst,
    clkCfgIf.clkGen     cfg,
    symbolReadIf.clkGen rd,
    output logic        symbolClk,
    output symbol_t     symbolData
);

    logic [1:0] divider;

    // Divide by four, one bit changes per step
    always_ff @(posedge dllOutputClk) begin
        if (rst) begin
            divider <= 2'b00;
        end else if (cfg.run) begin
            divider <= grayNext(divider);
        end
    end

    // One read per symbol period
    assign rd.readStrobe = cfg.run && (divider == 2'b00);

    always_ff @(posedge dllOutputClk) begin
        if (rst) begin
            symbolClk <= 1'b0;
        end else begin
            symbolClk <= phaseTap(cfg.phase, divider);
        end
    end

    // Hold the last symbol when nothing was popped
    always_ff @(posedge dllOutputClk) begin
        if (rst) begin
            symbolData <= '0;
        end else if (rd.valid) begin
            symbolData <= rd.symbol;
        end
    end

endmodule
